// File: rtl/elink_consts.svh
// elink receive constants

`ifndef ELINK_CONSTS_SVH
`define ELINK_CONSTS_SVH

// ##########################################################################
// packet and frame
// ##########################################################################

`define ERX_PW          104          // mesh packet width
`define ERX_WORDS       7            // 16-bit link words per frame

// ##########################################################################
// register window
// ##########################################################################

// dstaddr[31:6] must match this to hit the register block
`define ERX_BASE        26'h0_2f0_00
`define ERX_DEPTH       16           // register memory depth, in words

// ##########################################################################
// read response queue
// ##########################################################################

`define ERX_QDEPTH      4            // response queue entries
`define ERX_WAIT_LEVEL  2            // fill level that raises rx_rd_wait

`endif

// File: rtl/elink_pkg.sv
// elink receive types

package elink_pkg;

   typedef logic [31:0] addr_t;      // mesh address
   typedef logic [31:0] data_t;      // data word
   typedef logic [3:0]  ctrl_t;      // ctrlmode
   typedef logic [1:0]  dmode_t;     // 0 byte, 1 half, 2 word, 3 double
   typedef logic [15:0] link_word_t; // one de-serialized link word

   // mesh packet, msb first
   typedef struct packed
   {
      addr_t  srcaddr;               // 103:72
      data_t  data;                  // 71:40
      addr_t  dstaddr;               // 39:8
      ctrl_t  ctrlmode;              // 7:4
      dmode_t datamode;              // 3:2
      logic   write;                 // 1
      logic   access;                // 0
   } emesh_pkt_t;

   // decoded request, also reused for the read response
   typedef struct packed
   {
      logic       valid;
      logic       write;
      dmode_t     datamode;
      ctrl_t      ctrlmode;
      logic [3:0] widx;              // word index, dstaddr[5:2]
      logic [1:0] lane;              // byte lane, dstaddr[1:0]
      data_t      data;              // write data or read data
      addr_t      srcaddr;           // where the response goes
      addr_t      dstaddr;           // full target address
   } erx_cmd_t;

   // response queue fill state
   typedef enum logic [1:0]
   {
      rq_empty,
      rq_partial,
      rq_full
   } rq_state_t;

endpackage

// File: rtl/erx_io.sv
// link frame to mesh packet

`include "elink_consts.svh"

module erx_io
(
   input  logic                   reset,     // async, active high
   input  logic                   rx_lclk,
   input  logic                   rx_frame,  // high for a whole frame
   input  elink_pkg::link_word_t  rx_word,
   output elink_pkg::emesh_pkt_t  pkt,
   output logic                   pkt_valid, // one-cycle pulse
   output logic                   pkt_burst  // packet is a burst continuation
);

   import elink_pkg::*;

   logic [`ERX_WORDS-1:0]    rx_pointer;    // one-hot word slot
   logic [`ERX_WORDS*16-1:0] rx_sample;     // raw frame, word 1 at the low end
   logic                     access;        // last word just landed
   logic                     valid_q;       // packet reshuffled
   logic                     burst_detect;  // frame ran past the last word

   // ########################################################################
   // word capture
   // ########################################################################

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         rx_pointer <= '0;
      else if (!rx_frame)
         rx_pointer <= `ERX_WORDS'(1);                  // idle, ready for word 1
      else if (rx_pointer[`ERX_WORDS-1])
         rx_pointer <= `ERX_WORDS'(1) << 3;             // burst refills slots 3..6
      else
         rx_pointer <= rx_pointer << 1;
   end

   // payload only, no reset
   always_ff @(posedge rx_lclk)
   begin
      for (int i = 0; i < `ERX_WORDS; i++)
      begin
         if (rx_frame && rx_pointer[i])
            rx_sample[i*16 +: 16] <= rx_word;
      end
   end

   // ########################################################################
   // valid pipeline and burst flag
   // ########################################################################

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         access    <= 1'b0;
         valid_q   <= 1'b0;
         pkt_valid <= 1'b0;
      end
      else
      begin
         access    <= rx_frame & rx_pointer[`ERX_WORDS-1]; // last slot written
         valid_q   <= access;                              // reshuffle done
         pkt_valid <= valid_q;                             // to decode
      end
   end

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         burst_detect <= 1'b0;
      else if (access && rx_frame)
         burst_detect <= 1'b1;          // frame kept going, next packet is burst
      else if (!rx_frame)
         burst_detect <= 1'b0;
   end

   // ########################################################################
   // reshuffle into packet fields
   // ########################################################################

   always_ff @(posedge rx_lclk)
   begin
      if (access)
      begin
         pkt_burst    <= burst_detect;  // lags one packet on purpose
         pkt.access   <= rx_sample[40];
         pkt.write    <= rx_sample[41];
         pkt.datamode <= rx_sample[43:42];
         pkt.ctrlmode <= rx_sample[15:12];
         pkt.dstaddr  <= {rx_sample[11:8], rx_sample[23:16], rx_sample[31:24],
                          rx_sample[39:32], rx_sample[47:44]};
         pkt.data     <= {rx_sample[55:48], rx_sample[63:56],
                          rx_sample[71:64], rx_sample[79:72]};
         pkt.srcaddr  <= {rx_sample[87:80], rx_sample[95:88],
                          rx_sample[103:96], rx_sample[111:104]};
      end
   end

endmodule

// File: rtl/erx_decode.sv
// request decode

`include "elink_consts.svh"

module erx_decode
(
   input  logic                  reset,
   input  logic                  rx_lclk,
   input  elink_pkg::emesh_pkt_t pkt,
   input  logic                  pkt_valid,
   input  logic                  pkt_burst,
   output elink_pkg::erx_cmd_t   cmd
);

   import elink_pkg::*;

   addr_t last_dst;   // address of the previous packet
   addr_t dst;        // effective address of this packet
   logic  in_window;
   logic  mode_ok;
   logic  accept;

   // burst continuations walk forward one double word
   assign dst       = pkt_burst ? last_dst + 32'd8 : pkt.dstaddr;
   assign in_window = (dst[31:6] == `ERX_BASE);
   assign mode_ok   = (pkt.datamode != 2'd3);  // double not supported
   assign accept    = pkt.access & in_window & mode_ok;

   always_ff @(posedge rx_lclk)
   begin
      if (pkt_valid)
         last_dst <= dst;   // chains through a whole burst
   end

   // ########################################################################
   // command register
   // ########################################################################

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         cmd <= '0;
      else
      begin
         cmd.valid <= pkt_valid & accept;   // misses just vanish
         if (pkt_valid)
         begin
            cmd.write    <= pkt.write;
            cmd.datamode <= pkt.datamode;
            cmd.ctrlmode <= pkt.ctrlmode;
            cmd.widx     <= dst[5:2];
            cmd.lane     <= dst[1:0];
            cmd.data     <= pkt.data;
            cmd.srcaddr  <= pkt.srcaddr;
            cmd.dstaddr  <= dst;
         end
      end
   end

endmodule

// File: rtl/erx_execute.sv
// register memory access

`include "elink_consts.svh"

module erx_execute
(
   input  logic                reset,
   input  logic                rx_lclk,
   input  elink_pkg::erx_cmd_t cmd,
   output elink_pkg::erx_cmd_t rsp
);

   import elink_pkg::*;

   data_t mem [`ERX_DEPTH];   // register file
   logic  do_write;
   logic  do_read;

   assign do_write = cmd.valid & cmd.write;
   assign do_read  = cmd.valid & ~cmd.write;

   // merge new data into the old word by datamode and lane
   function automatic data_t merge_word(input data_t old_w, input data_t new_w,
                                        input dmode_t mode, input logic [1:0] lane);
      data_t res;
      res = old_w;
      case (mode)
         2'd0:    res[lane*8 +: 8]      = new_w[7:0];   // byte
         2'd1:    res[lane[1]*16 +: 16] = new_w[15:0];  // half, lane[0] ignored
         default: res                   = new_w;        // word
      endcase
      return res;
   endfunction

   // ########################################################################
   // memory, cleared on reset
   // ########################################################################

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < `ERX_DEPTH; i++)
            mem[i] <= '0;
      end
      else if (do_write)
         mem[cmd.widx] <= merge_word(mem[cmd.widx], cmd.data, cmd.datamode, cmd.lane);
   end

   // read port, old data at this edge
   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         rsp <= '0;
      else
      begin
         rsp.valid <= do_read;   // writes give no response
         if (do_read)
         begin
            rsp.write    <= 1'b0;
            rsp.datamode <= cmd.datamode;
            rsp.ctrlmode <= cmd.ctrlmode;
            rsp.widx     <= cmd.widx;
            rsp.lane     <= cmd.lane;
            rsp.data     <= mem[cmd.widx];   // whole word
            rsp.srcaddr  <= cmd.srcaddr;
            rsp.dstaddr  <= cmd.dstaddr;
         end
      end
   end

endmodule

// File: rtl/erx_result.sv
// read response queue

`include "elink_consts.svh"

module erx_result
(
   input  logic                  reset,
   input  logic                  rx_lclk,
   input  elink_pkg::erx_cmd_t   rsp,
   input  logic                  tx_wait,
   output elink_pkg::emesh_pkt_t tx_pkt,
   output logic                  tx_access,
   output logic                  rx_rd_wait
);

   import elink_pkg::*;

   logic [`ERX_PW-1:0]                 q_mem [`ERX_QDEPTH];  // response slots
   logic [$clog2(`ERX_QDEPTH)-1:0]     wr_ptr, rd_ptr;
   logic [$clog2(`ERX_QDEPTH+1)-1:0]   count, count_next;
   rq_state_t                          state;
   emesh_pkt_t                         rsp_pkt;
   logic                               push, pop;

   // response goes back to the requester as a word write
   always_comb
   begin
      rsp_pkt          = '0;
      rsp_pkt.access   = 1'b1;
      rsp_pkt.write    = 1'b1;
      rsp_pkt.datamode = 2'd2;
      rsp_pkt.ctrlmode = rsp.ctrlmode;
      rsp_pkt.dstaddr  = rsp.srcaddr;   // swap addresses
      rsp_pkt.data     = rsp.data;
      rsp_pkt.srcaddr  = rsp.dstaddr;
   end

   assign push = rsp.valid & (state != rq_full);  // sender paces, so never full here
   assign pop  = tx_access & ~tx_wait;            // transfer cycle

   always_comb
   begin
      count_next = count;
      if (push && !pop)
         count_next = count + 1'b1;
      else if (pop && !push)
         count_next = count - 1'b1;
   end

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         state  <= rq_empty;
      end
      else
      begin
         wr_ptr <= wr_ptr + push;
         rd_ptr <= rd_ptr + pop;
         count  <= count_next;
         if (count_next == 0)
            state <= rq_empty;
         else if (count_next == `ERX_QDEPTH)
            state <= rq_full;
         else
            state <= rq_partial;
      end
   end

   always_ff @(posedge rx_lclk)
   begin
      if (push)
         q_mem[wr_ptr] <= rsp_pkt;
   end

   assign tx_pkt     = emesh_pkt_t'(q_mem[rd_ptr]);     // head, held until popped
   assign tx_access  = (state != rq_empty);
   assign rx_rd_wait = (count >= `ERX_WAIT_LEVEL);      // leaves room for two in flight

endmodule

// File: rtl/erx_top.sv
// elink receive top

module erx_top
(
   input  logic                  reset,
   input  logic                  rx_lclk,
   input  logic                  rx_frame,
   input  elink_pkg::link_word_t rx_word,
   input  logic                  tx_wait,
   output elink_pkg::emesh_pkt_t tx_pkt,
   output logic                  tx_access,
   output logic                  rx_rd_wait
);

   import elink_pkg::*;

   emesh_pkt_t pkt;         // assembled packet
   logic       pkt_valid;
   logic       pkt_burst;
   erx_cmd_t   cmd;         // decoded request
   erx_cmd_t   rsp;         // read data

   // link words to packet
   erx_io i_io
   (
      .reset      (reset),
      .rx_lclk    (rx_lclk),
      .rx_frame   (rx_frame),
      .rx_word    (rx_word),
      .pkt        (pkt),
      .pkt_valid  (pkt_valid),
      .pkt_burst  (pkt_burst)
   );

   erx_decode i_decode
   (
      .reset      (reset),
      .rx_lclk    (rx_lclk),
      .pkt        (pkt),
      .pkt_valid  (pkt_valid),
      .pkt_burst  (pkt_burst),
      .cmd        (cmd)
   );

   erx_execute i_execute (.reset(reset), .rx_lclk(rx_lclk), .cmd(cmd), .rsp(rsp));

   // responses out, pushback to the link
   erx_result i_result
   (
      .reset      (reset),
      .rx_lclk    (rx_lclk),
      .rsp        (rsp),
      .tx_wait    (tx_wait),
      .tx_pkt     (tx_pkt),
      .tx_access  (tx_access),
      .rx_rd_wait (rx_rd_wait)
   );

endmodule

// File: verif/erx_assertions.sv
// output handshake assertions

module erx_assertions
(
   input logic                  reset,
   input logic                  rx_lclk,
   input logic                  tx_wait,
   input logic                  tx_access,
   input logic                  rx_rd_wait,
   input elink_pkg::emesh_pkt_t tx_pkt
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   // a stalled head stays put and stays offered
   hold_on_wait: assert property (@(posedge rx_lclk) disable iff (reset)
                                  tx_access && tx_wait |=> tx_access && $stable(tx_pkt))
      else
      begin
         $error("tx_pkt changed or tx_access dropped while tx_wait was high");
         fail_count++;
      end

   quiet_in_reset: assert property (@(posedge rx_lclk) reset |-> !tx_access && !rx_rd_wait)
      else
      begin
         $error("tx_access or rx_rd_wait high during reset");
         fail_count++;
      end

endmodule

bind erx_top erx_assertions i_assertions
(
   .reset      (reset),
   .rx_lclk    (rx_lclk),
   .tx_wait    (tx_wait),
   .tx_access  (tx_access),
   .rx_rd_wait (rx_rd_wait),
   .tx_pkt     (tx_pkt)
);

// File: verif/erx_checker.sv
// response checker

`include "elink_consts.svh"

module erx_checker
(
   input logic                  reset,
   input logic                  rx_lclk,
   input logic                  tx_access,
   input logic                  tx_wait,
   input elink_pkg::emesh_pkt_t tx_pkt
);

   timeunit 1ns;
   timeprecision 100ps;

   import elink_pkg::*;

   emesh_pkt_t exp_q [$];      // responses the model expects, in order
   string      test_name = "none";
   int         test_checks;
   int         test_errors;
   int         total_checks;
   int         total_errors;
   int         tests_done;

   task automatic push_expected(input emesh_pkt_t p);
      exp_q.push_back(p);
   endtask

   function automatic int pending();
      return exp_q.size();
   endfunction

   // queue fill equals responses still owed once all reads have landed
   task automatic check_rd_wait(input logic actual);
      logic expected;
      expected = (exp_q.size() >= `ERX_WAIT_LEVEL);
      if (actual !== expected)
      begin
         $display("error test %s: rx_rd_wait expected %b actual %b",
                  test_name, expected, actual);
         test_errors++;
         total_errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic finish_test();
      if (exp_q.size() != 0)
      begin
         $display("test %s ended with %0d responses never sent", test_name, exp_q.size());
         test_errors  += exp_q.size();
         total_errors += exp_q.size();
         exp_q.delete();
      end
      $display("test %s done: %0d responses, %0d errors", test_name, test_checks, test_errors);
      tests_done++;
   endtask

   task automatic report_counts(input int assert_fails);
      total_errors += assert_fails;
      $display("%0d tests, %0d responses checked, %0d errors, %0d assertion failures",
               tests_done, total_checks, total_errors, assert_fails);
   endtask

   // ########################################################################
   // compare on transfer
   // ########################################################################

   // negedge, inputs and DUT state are settled here
   always @(negedge rx_lclk)
   begin
      emesh_pkt_t exp;
      if (!reset && tx_access && !tx_wait)
      begin
         if (exp_q.size() == 0)
         begin
            $display("test %s: response to %h sent but none was expected",
                     test_name, tx_pkt.dstaddr);
            test_errors++;
            total_errors++;
         end
         else
         begin
            exp = exp_q.pop_front();
            test_checks++;
            total_checks++;
            if (tx_pkt !== exp)
            begin
               $display("error test %s: expected %h actual %h", test_name, exp, tx_pkt);
               test_errors++;
               total_errors++;
            end
         end
      end
   end

endmodule

// File: verif/erx_tb.sv
// elink receive testbench

`include "elink_consts.svh"

module erx_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import elink_pkg::*;

   logic       reset;
   logic       rx_lclk;
   logic       rx_frame;
   link_word_t rx_word;
   logic       tx_wait;
   emesh_pkt_t tx_pkt;
   logic       tx_access;
   logic       rx_rd_wait;

   data_t      model_mem [`ERX_DEPTH];  // expected register contents
   int         frames_sent;
   int         cycles;
   logic       long_wait;               // long tx_wait stretches
   int         wait_run;

   erx_top i_dut
   (
      .reset      (reset),
      .rx_lclk    (rx_lclk),
      .rx_frame   (rx_frame),
      .rx_word    (rx_word),
      .tx_wait    (tx_wait),
      .tx_pkt     (tx_pkt),
      .tx_access  (tx_access),
      .rx_rd_wait (rx_rd_wait)
   );

   erx_checker i_checker
   (
      .reset      (reset),
      .rx_lclk    (rx_lclk),
      .tx_access  (tx_access),
      .tx_wait    (tx_wait),
      .tx_pkt     (tx_pkt)
   );

   // ########################################################################
   // clock, timeout, tx_wait
   // ########################################################################

   initial rx_lclk = 1'b0;

   always #20 rx_lclk = ~rx_lclk;   // 40 ns period

   always @(posedge rx_lclk)
   begin
      cycles++;
      if (cycles > 64 * frames_sent + 500)
      begin
         $display("run timed out after %0d cycles with %0d frames sent", cycles, frames_sent);
         $display("Something failed");
         $finish;
      end
   end

   // random back-pressure from the outgoing side
   always @(posedge rx_lclk)
   begin
      #5;
      if (wait_run == 0)
      begin
         if (long_wait)
         begin
            tx_wait  = ($urandom % 100) < 60;
            wait_run = 1 + $urandom % 16;       // stretch length
         end
         else
         begin
            tx_wait  = ($urandom % 100) < 25;
            wait_run = 1;
         end
      end
      wait_run--;
   end

   // ########################################################################
   // frame building and model
   // ########################################################################

   // link layout, word 1 lands in bits 15:0
   function automatic logic [111:0] pack_sample(input emesh_pkt_t p);
      logic [111:0] s;
      s          = '0;
      s[15:12]   = p.ctrlmode;
      s[11:8]    = p.dstaddr[31:28];
      s[23:16]   = p.dstaddr[27:20];
      s[31:24]   = p.dstaddr[19:12];
      s[39:32]   = p.dstaddr[11:4];
      s[47:44]   = p.dstaddr[3:0];
      s[40]      = p.access;
      s[41]      = p.write;
      s[43:42]   = p.datamode;
      s[55:48]   = p.data[31:24];
      s[63:56]   = p.data[23:16];
      s[71:64]   = p.data[15:8];
      s[79:72]   = p.data[7:0];
      s[87:80]   = p.srcaddr[31:24];
      s[95:88]   = p.srcaddr[23:16];
      s[103:96]  = p.srcaddr[15:8];
      s[111:104] = p.srcaddr[7:0];
      return s;
   endfunction

   function automatic addr_t win_addr(input int idx, input int lane);
      return {`ERX_BASE, idx[3:0], lane[1:0]};
   endfunction

   function automatic emesh_pkt_t make_req(input logic wr, input dmode_t mode,
                                           input addr_t dst, input data_t d);
      emesh_pkt_t p;
      p.access   = 1'b1;
      p.write    = wr;
      p.datamode = mode;
      p.ctrlmode = ctrl_t'($urandom);
      p.dstaddr  = dst;
      p.data     = d;
      p.srcaddr  = addr_t'($urandom);
      return p;
   endfunction

   // apply one packet to the memory image, queue the read response
   task automatic model_packet(input emesh_pkt_t p, input addr_t dst);
      emesh_pkt_t r;
      int         idx;
      data_t      w;
      idx = dst[5:2];
      if (p.access && dst[31:6] == `ERX_BASE && p.datamode != 2'd3)
      begin
         if (p.write)
         begin
            w = model_mem[idx];
            if (p.datamode == 2'd2)
               w = p.data;
            else if (p.datamode == 2'd1 && dst[1])
               w[31:16] = p.data[15:0];    // upper half
            else if (p.datamode == 2'd1)
               w[15:0] = p.data[15:0];
            else
               case (dst[1:0])
                  2'd0: w[7:0]   = p.data[7:0];
                  2'd1: w[15:8]  = p.data[7:0];
                  2'd2: w[23:16] = p.data[7:0];
                  2'd3: w[31:24] = p.data[7:0];
               endcase
            model_mem[idx] = w;
         end
         else
         begin
            r          = '0;
            r.access   = 1'b1;
            r.write    = 1'b1;
            r.datamode = 2'd2;
            r.ctrlmode = p.ctrlmode;
            r.dstaddr  = p.srcaddr;
            r.data     = model_mem[idx];
            r.srcaddr  = dst;
            i_checker.push_expected(r);
         end
      end
   endtask

   // ########################################################################
   // link driver
   // ########################################################################

   task automatic idle_cycle();
      @(posedge rx_lclk);
      #5;
      rx_frame = 1'b0;
      rx_word  = '0;
   endtask

   task automatic drive_word(input link_word_t w);
      @(posedge rx_lclk);
      #5;
      rx_frame = 1'b1;
      rx_word  = w;
   endtask

   // one frame plus ncont burst continuations
   task automatic drive_frame(input emesh_pkt_t p, input int ncont);
      logic [111:0] s;
      emesh_pkt_t   c;
      addr_t        dst;
      repeat (6) idle_cycle();        // earlier responses have reached the queue
      i_checker.check_rd_wait(rx_rd_wait);
      while (rx_rd_wait)
      begin
         idle_cycle();
         i_checker.check_rd_wait(rx_rd_wait);
      end
      s = pack_sample(p);
      for (int i = 0; i < 7; i++)
         drive_word(s[i*16 +: 16]);
      model_packet(p, p.dstaddr);
      dst = p.dstaddr;
      for (int k = 0; k < ncont; k++)
      begin
         c         = p;
         c.data    = data_t'($urandom);
         c.srcaddr = addr_t'($urandom);
         s         = pack_sample(c);
         for (int i = 3; i < 7; i++)
            drive_word(s[i*16 +: 16]);   // data and srcaddr only
         dst = dst + 32'd8;
         model_packet(c, dst);
      end
      frames_sent++;
   endtask

   task automatic end_test();
      int n;
      n = 0;
      idle_cycle();
      while (i_checker.pending() != 0 && n < 64 * `ERX_QDEPTH)
      begin
         idle_cycle();                // let the queue drain
         n++;
      end
      repeat (10) idle_cycle();       // catch stray responses
      i_checker.finish_test();
   endtask

   // ########################################################################
   // tests
   // ########################################################################

   task automatic word_write_read();
      int idx;
      i_checker.start_test("word_rw");
      repeat (8)
      begin
         idx = $urandom % 16;
         drive_frame(make_req(1'b1, 2'd2, win_addr(idx, 0), data_t'($urandom)), 0);
         drive_frame(make_req(1'b0, 2'd2, win_addr(idx, 0), '0), 0);
      end
      end_test();
   endtask

   task automatic byte_half_merge();
      int idx;
      i_checker.start_test("byte_half");
      for (int lane = 0; lane < 4; lane++)
      begin
         idx = $urandom % 16;
         drive_frame(make_req(1'b1, 2'd0, win_addr(idx, lane), data_t'($urandom)), 0);
         drive_frame(make_req(1'b0, 2'd2, win_addr(idx, 0), '0), 0);
         drive_frame(make_req(1'b1, 2'd1, win_addr(idx, lane), data_t'($urandom)), 0);
         drive_frame(make_req(1'b0, 2'd2, win_addr(idx, 0), '0), 0);
      end
      end_test();
   endtask

   task automatic dropped_requests();
      int         idx;
      addr_t      bad;
      emesh_pkt_t p;
      i_checker.start_test("dropped");
      repeat (4)
      begin
         idx = $urandom % 16;
         bad = {`ERX_BASE ^ (26'd1 << ($urandom % 26)), 4'(idx), 2'd0};
         drive_frame(make_req(1'b1, 2'd2, bad, data_t'($urandom)), 0);
         drive_frame(make_req(1'b0, 2'd2, bad, '0), 0);
         drive_frame(make_req(1'b1, 2'd3, win_addr(idx, 0), data_t'($urandom)), 0);
         drive_frame(make_req(1'b0, 2'd3, win_addr(idx, 0), '0), 0);
         p        = make_req(1'b1, 2'd2, win_addr(idx, 0), data_t'($urandom));
         p.access = 1'b0;             // no access bit
         drive_frame(p, 0);
      end
      for (int i = 0; i < `ERX_DEPTH; i++)
         drive_frame(make_req(1'b0, 2'd2, win_addr(i, 0), '0), 0);
      end_test();
   endtask

   task automatic burst_frames();
      int idx;
      int n;
      i_checker.start_test("burst");
      repeat (6)
      begin
         idx = $urandom % 12;          // continuations stay inside the window
         n   = 1 + $urandom % 2;
         drive_frame(make_req(1'b1, 2'd2, win_addr(idx, 0), data_t'($urandom)), n);
         drive_frame(make_req(1'b0, 2'd2, win_addr(idx, 0), '0), n);
      end
      end_test();
   endtask

   task automatic backpressure_reads();
      logic wr;
      i_checker.start_test("backpressure");
      long_wait = 1'b1;
      repeat (24)
      begin
         wr = ($urandom % 4) == 0;     // mostly reads
         drive_frame(make_req(wr, dmode_t'($urandom % 3),
                              win_addr($urandom % 16, $urandom % 4), data_t'($urandom)),
                     $urandom % 3);
      end
      end_test();
      long_wait = 1'b0;
   endtask

   // ########################################################################
   // main sequence
   // ########################################################################

   initial
   begin
      void'($urandom(32'h0f50_9b49));
      reset       = 1'b1;
      rx_frame    = 1'b0;
      rx_word     = '0;
      tx_wait     = 1'b0;
      long_wait   = 1'b0;
      wait_run    = 0;
      frames_sent = 0;
      cycles      = 0;
      for (int i = 0; i < `ERX_DEPTH; i++)
         model_mem[i] = '0;            // memory clears on reset
      repeat (16) @(posedge rx_lclk);
      #5;
      reset = 1'b0;

      word_write_read();
      byte_half_merge();
      dropped_requests();
      burst_frames();
      backpressure_reads();

      i_checker.report_counts(i_dut.i_assertions.fail_count);
      if (i_checker.total_errors == 0 && i_dut.i_assertions.fail_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+rtl
rtl/elink_pkg.sv
rtl/erx_io.sv
rtl/erx_decode.sv
rtl/erx_execute.sv
rtl/erx_result.sv
rtl/erx_top.sv
verif/erx_assertions.sv
verif/erx_checker.sv
verif/erx_tb.sv
